//--- src/cphyRxPkg.sv
/*
 Shared types and constants for the C-PHY HS receive path.
 Symbol values use a plain base-5 rule, not the real C-PHY 16-bit table.
 Wire states are the raw AB/BC/CA comparator bits, 000 and 111 illegal.
*/
`default_nettype none

package cphyRxPkg;

    // ============================================================
    // Wire states
    // ============================================================
    typedef logic [2:0] wireState_t;                  // {AB, BC, CA}

    localparam wireState_t WsPosX = 3'b100;
    localparam wireState_t WsNegX = 3'b011;
    localparam wireState_t WsPosY = 3'b010;
    localparam wireState_t WsNegY = 3'b101;
    localparam wireState_t WsPosZ = 3'b001;
    localparam wireState_t WsNegZ = 3'b110;

    typedef enum logic [1:0] {LetterX, LetterY, LetterZ} wireLetter_t;

    // ============================================================
    // Symbols and groups
    // ============================================================
    typedef struct packed {
        logic flip;
        logic rotation;
        logic polarity;
    } hsSymbol_t;

    typedef struct packed {
        hsSymbol_t symbol;
        logic      valid;                             // One beat per strobe
        logic      bad;                               // Repeat or illegal state
    } symbolBeat_t;

    localparam int SymbolsPerWord = 7;
    localparam int WordValueWidth = 17;               // 4 * 19531 = 78124 max
    localparam int unsigned MaxWordValue = 65535;

    typedef logic [2:0] symValue_t;                   // 0..4

    typedef struct packed {
        hsSymbol_t [SymbolsPerWord-1:0] sym;          // Entry 0 arrived first
        logic                           bad;
    } symbolGroup_t;

    typedef struct packed {
        logic [15:0] data;
        logic        invalidCode;
    } hsWord_t;

    // Sync word in arrival order
    localparam symValue_t SyncWord [SymbolsPerWord] = '{3, 4, 4, 4, 4, 4, 3};

    // Weight of entry i is 5 ** (6 - i)
    localparam int unsigned SymWeight [SymbolsPerWord] = '{15625, 3125, 625, 125, 25, 5, 1};

    // Letter is where the odd bit sits
    function automatic wireLetter_t wireLetter(wireState_t ws);
        case (ws)
            WsPosX, WsNegX: return LetterX;
            WsPosY, WsNegY: return LetterY;
            WsPosZ, WsNegZ: return LetterZ;
            default:        return LetterX;          // Illegal, caller checks
        endcase
    endfunction

    function automatic logic wireIsLegal(wireState_t ws);
        return (ws != 3'b000) && (ws != 3'b111);
    endfunction

    function automatic logic wireIsPositive(wireState_t ws);
        return ws inside {WsPosX, WsPosY, WsPosZ};    // Exactly one bit set
    endfunction

    function automatic symValue_t symValue(hsSymbol_t s);
        return s.flip ? symValue_t'(4) : symValue_t'({s.rotation, s.polarity});
    endfunction

endpackage

`default_nettype wire

//--- src/wireStateDecoder.sv
/*
 Wire-state to symbol decoder, one registered beat per state after the first.
 A repeated state or an illegal code gives a bad beat with a zero symbol.
 HsRxEn low drops the previous state, so the next state starts fresh.
*/
`timescale 1ns/1ps
`default_nettype none

module wireStateDecoder import cphyRxPkg::*;
(
    input  logic        RxSymClkHS,
    input  logic        RstN,
    input  logic        HsRxEn,
    input  wireState_t  WireState,
    output symbolBeat_t beat
);

    wireState_t  prevState;                           // Last sampled state
    logic        prevValid;                           // prevState is usable
    wireLetter_t prevLetter;
    wireLetter_t curLetter;
    wireLetter_t aheadLetter;                         // Letter after prevLetter
    logic        legalPair;
    hsSymbol_t   nextSymbol;

    assign prevLetter = wireLetter(prevState);
    assign curLetter  = wireLetter(WireState);

    // x -> y -> z -> x
    always_comb
    begin
        case (prevLetter)
            LetterX: aheadLetter = LetterY;
            LetterY: aheadLetter = LetterZ;
            default: aheadLetter = LetterX;
        endcase
    end

    // Both legal and an actual transition
    assign legalPair = wireIsLegal(prevState) && wireIsLegal(WireState)
                       && (prevState != WireState);

    // ============================================================
    // Symbol rule
    // ============================================================
    always_comb
    begin
        nextSymbol = '0;
        if (legalPair)
        begin
            if (prevLetter == curLetter)
                nextSymbol.flip = 1'b1;               // Same letter, sign flipped
            else
            begin
                nextSymbol.rotation = (curLetter == aheadLetter);     // Forward turn
                nextSymbol.polarity = wireIsPositive(prevState)
                                      != wireIsPositive(WireState);
            end
        end
    end

    always_ff @(posedge RxSymClkHS or negedge RstN)
    begin
        if (!RstN)
        begin
            prevState <= '0;
            prevValid <= 1'b0;
            beat      <= '0;
        end
        else if (!HsRxEn)
        begin
            prevState <= '0;                          // Forget the old burst
            prevValid <= 1'b0;
            beat      <= '0;
        end
        else
        begin
            prevState    <= WireState;
            prevValid    <= 1'b1;
            beat.valid   <= prevValid;                // First state makes no beat
            beat.bad     <= prevValid && !legalPair;
            beat.symbol  <= prevValid ? nextSymbol : '0;
        end
    end

    // Downstream sums the symbol blindly, so a bad beat must read as zero
    badBeatZero: assert property (@(posedge RxSymClkHS) disable iff (!RstN)
        beat.bad |-> (beat.valid && beat.symbol == '0))
        else $error("Bad beat carries symbol %0d", beat.symbol);

endmodule

`default_nettype wire

//--- src/syncDetector.sv
/*
 Start-of-transmission search on the beat stream.
 One outcome per burst: sync, a bad beat, or SyncTimeout beats without sync.
 After any of them the search stops until HsRxEn goes low.
*/
`timescale 1ns/1ps
`default_nettype none

module syncDetector import cphyRxPkg::*;
#(
    parameter int SyncTimeout = 64                    // Beats allowed before sync
)
(
    input  logic        RxSymClkHS,
    input  logic        RstN,
    input  logic        HsRxEn,
    input  symbolBeat_t beat,
    output logic        wordAlign,
    output logic        RxSyncHS,
    output logic        RxActiveHS,
    output logic        ErrSotHS,
    output logic        ErrSotSyncHS
);

    localparam int CntW = $clog2(SyncTimeout + 1);

    typedef enum logic [1:0] {Searching, Aligned, Failed} syncState_t;

    syncState_t                         state;
    logic [CntW-1:0]                    beatCount;    // Beats seen in this search
    symValue_t [SymbolsPerWord-1:0]     histSym;      // Index 0 oldest
    logic [SymbolsPerWord-1:0]          histBad;
    symValue_t [SymbolsPerWord-1:0]     nextSym;
    logic [SymbolsPerWord-1:0]          nextBad;
    logic                               syncHit;

    // History with the current beat shifted in on top
    assign nextSym = {symValue(beat.symbol), histSym[SymbolsPerWord-1:1]};
    assign nextBad = {beat.bad, histBad[SymbolsPerWord-1:1]};

    always_comb
    begin
        syncHit = (nextBad == '0);
        for (int i = 0; i < SymbolsPerWord; i++)
            syncHit = syncHit && (nextSym[i] == SyncWord[i]);
    end

    // ============================================================
    // Search state
    // ============================================================
    always_ff @(posedge RxSymClkHS or negedge RstN)
    begin
        if (!RstN)
        begin
            state        <= Searching;
            beatCount    <= '0;
            histSym      <= '0;
            histBad      <= '0;
            RxSyncHS     <= 1'b0;
            ErrSotHS     <= 1'b0;
            ErrSotSyncHS <= 1'b0;
        end
        else
        begin
            RxSyncHS     <= 1'b0;                     // Pulses by default
            ErrSotHS     <= 1'b0;
            ErrSotSyncHS <= 1'b0;
            if (!HsRxEn)
            begin
                state     <= Searching;               // Rearm for next burst
                beatCount <= '0;
                histSym   <= '0;
                histBad   <= '0;
            end
            else if (state == Searching && beat.valid)
            begin
                histSym   <= nextSym;
                histBad   <= nextBad;
                beatCount <= beatCount + 1'b1;
                if (beat.bad)
                begin
                    ErrSotHS <= 1'b1;                 // Corrupt preamble
                    state    <= Failed;
                end
                else if (syncHit)
                begin
                    RxSyncHS <= 1'b1;
                    state    <= Aligned;
                end
                else if (beatCount == CntW'(SyncTimeout - 1))
                begin
                    ErrSotSyncHS <= 1'b1;             // Gave up waiting
                    state        <= Failed;
                end
            end
        end
    end

    assign wordAlign  = (state == Aligned);
    assign RxActiveHS = (state == Aligned);

    syncXorErr: assert property (@(posedge RxSymClkHS) disable iff (!RstN)
        RxSyncHS |-> !(ErrSotHS || ErrSotSyncHS))
        else $error("Sync and SoT error in one cycle");

endmodule

`default_nettype wire

//--- src/symbolDeserializer.sv
/*
 Groups aligned beats by seven and strobes each group for one cycle.
 Counting starts with the first beat after wordAlign rises.
 The group register changes right after the strobe; sample it on groupValid.
*/
`timescale 1ns/1ps
`default_nettype none

module symbolDeserializer import cphyRxPkg::*;
(
    input  logic         RxSymClkHS,
    input  logic         RstN,
    input  logic         wordAlign,
    input  symbolBeat_t  beat,
    output symbolGroup_t group,
    output logic         groupValid
);

    localparam logic [2:0] LastIdx = 3'(SymbolsPerWord - 1);

    logic [2:0] count;                                // Slot for the next beat
    logic       take;

    assign take = wordAlign && beat.valid;

    // ============================================================
    // Slot counter and strobe
    // ============================================================
    always_ff @(posedge RxSymClkHS or negedge RstN)
    begin
        if (!RstN)
        begin
            count      <= '0;
            groupValid <= 1'b0;
        end
        else
        begin
            groupValid <= 1'b0;
            if (!wordAlign)
                count <= '0;                          // Lost alignment
            else if (beat.valid)
            begin
                if (count == LastIdx)
                begin
                    count      <= '0;                 // Next group starts at once
                    groupValid <= 1'b1;
                end
                else
                    count <= count + 1'b1;
            end
        end
    end

    // Group payload loaded beat by beat
    always_ff @(posedge RxSymClkHS)
    begin
        if (take)
        begin
            group.sym[count] <= beat.symbol;
            // First slot restarts the error flag
            group.bad <= (count == '0) ? beat.bad : (group.bad | beat.bad);
        end
    end

    countRange: assert property (@(posedge RxSymClkHS) disable iff (!RstN)
        count <= LastIdx)
        else $error("Symbol count out of range: %0d", count);

endmodule

`default_nettype wire

//--- src/symbolDemapper.sv
/*
 Base-5 demapper: seven symbol values, entry 0 most significant.
 Values above 65535 or a group with a bad beat raise the invalid flag.
 Data is the value modulo 65536; one word per groupValid, no stall.
*/
`timescale 1ns/1ps
`default_nettype none

module symbolDemapper import cphyRxPkg::*;
(
    input  logic         RxSymClkHS,
    input  logic         RstN,
    input  symbolGroup_t group,
    input  logic         groupValid,
    output logic [15:0]  RxDataHS,
    output logic         RxInvalidCodeHS,
    output logic         RxValidHS
);

    logic [WordValueWidth-1:0] wordValue;             // Up to 78124
    hsWord_t                   wordNext;
    hsWord_t                   wordReg;

    // ============================================================
    // Constant-weight sum
    // ============================================================
    always_comb
    begin
        wordValue = '0;
        for (int i = 0; i < SymbolsPerWord; i++)
            wordValue = wordValue
                        + WordValueWidth'(symValue(group.sym[i]) * SymWeight[i]);
    end

    always_comb
    begin
        wordNext.data        = wordValue[15:0];       // Modulo 65536
        wordNext.invalidCode = (wordValue > MaxWordValue) || group.bad;
    end

    // Output word and strobe
    always_ff @(posedge RxSymClkHS or negedge RstN)
    begin
        if (!RstN)
        begin
            wordReg   <= '0;
            RxValidHS <= 1'b0;
        end
        else
        begin
            RxValidHS <= groupValid;                  // One cycle behind group
            if (groupValid)
                wordReg <= wordNext;                  // Hold between words
        end
    end

    assign RxDataHS        = wordReg.data;
    assign RxInvalidCodeHS = wordReg.invalidCode;

endmodule

`default_nettype wire

//--- src/cphyRxTop.sv
/*
 C-PHY HS receive path on a single RxSymClkHS clock.
 HsRxEn must stay high for the whole burst; dropping it ends the burst.
 RxValidHS lags the state completing a word's last symbol by three edges.
*/
`timescale 1ns/1ps
`default_nettype none

module cphyRxTop import cphyRxPkg::*;
#(
    parameter int SyncTimeout = 64                    // Beats before ErrSotSyncHS
)
(
    input  logic        RxSymClkHS,
    input  logic        RstN,
    input  logic        HsRxEn,
    input  wireState_t  WireState,
    output logic [15:0] RxDataHS,
    output logic        RxValidHS,
    output logic        RxInvalidCodeHS,
    output logic        RxSyncHS,
    output logic        RxActiveHS,
    output logic        ErrSotHS,
    output logic        ErrSotSyncHS
);

    symbolBeat_t  beat;                               // Decoder to sync and deser
    logic         wordAlign;
    symbolGroup_t group;
    logic         groupValid;

    // ============================================================
    // Receive chain
    // ============================================================
    wireStateDecoder wireStateDecoder_i (
        .RxSymClkHS   (RxSymClkHS),
        .RstN         (RstN),
        .HsRxEn       (HsRxEn),
        .WireState    (WireState),
        .beat         (beat)
    );

    syncDetector #(
        .SyncTimeout  (SyncTimeout)
    ) syncDetector_i (
        .RxSymClkHS   (RxSymClkHS),
        .RstN         (RstN),
        .HsRxEn       (HsRxEn),
        .beat         (beat),
        .wordAlign    (wordAlign),
        .RxSyncHS     (RxSyncHS),
        .RxActiveHS   (RxActiveHS),
        .ErrSotHS     (ErrSotHS),
        .ErrSotSyncHS (ErrSotSyncHS)
    );

    symbolDeserializer symbolDeserializer_i (
        .RxSymClkHS   (RxSymClkHS),
        .RstN         (RstN),
        .wordAlign    (wordAlign),
        .beat         (beat),
        .group        (group),
        .groupValid   (groupValid)
    );

    symbolDemapper symbolDemapper_i (
        .RxSymClkHS      (RxSymClkHS),
        .RstN            (RstN),
        .group           (group),
        .groupValid      (groupValid),
        .RxDataHS        (RxDataHS),
        .RxInvalidCodeHS (RxInvalidCodeHS),
        .RxValidHS       (RxValidHS)
    );

endmodule

`default_nettype wire

//--- tb/cphyRxTb.sv
/*
 Testbench for the C-PHY HS receive path with SyncTimeout set to 40.
 Wire states come from a tracked letter and sign per the symbol rule.
 Expected words come from a base-5 reference, checked in arrival order.
*/
`timescale 1ns/1ps
`default_nettype none

module cphyRxTb import cphyRxPkg::*;
();

    localparam int ClkPeriod     = 20;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 2000;
    localparam int DrainLimit    = 60;                // Cycles to wait for results

    typedef logic [6:0][2:0] symList_t;               // Entry 0 sent first

    // Sync word in arrival order
    localparam symList_t SyncSymbols = {3'd3, 3'd4, 3'd4, 3'd4, 3'd4, 3'd4, 3'd3};

    logic        RxSymClkHS;
    logic        RstN;
    logic        HsRxEn;
    wireState_t  WireState;
    logic [15:0] RxDataHS;
    logic        RxValidHS;
    logic        RxInvalidCodeHS;
    logic        RxSyncHS;
    logic        RxActiveHS;
    logic        ErrSotHS;
    logic        ErrSotSyncHS;

    int      seed = 32'h7ce3156d;
    int      curLetter;                               // 0 x, 1 y, 2 z
    logic    curPos;                                  // Sign of last driven state
    hsWord_t expQ[$];                                 // Words still to arrive
    string   testName;
    int      errorCount = 0;
    int      errorsAtStart;
    int      testsRun = 0;
    int      testsFailed = 0;
    int      wordsChecked = 0;
    int      syncCount = 0;
    int      errSotCount = 0;
    int      errSotSyncCount = 0;
    int      validCount = 0;
    int      activeCycles = 0;
    int      snapSync;
    int      snapSot;
    int      snapSotSync;
    int      snapValid;
    int      snapActive;

    cphyRxTop #(
        .SyncTimeout     (40)
    ) cphyRxTop_i (
        .RxSymClkHS      (RxSymClkHS),
        .RstN            (RstN),
        .HsRxEn          (HsRxEn),
        .WireState       (WireState),
        .RxDataHS        (RxDataHS),
        .RxValidHS       (RxValidHS),
        .RxInvalidCodeHS (RxInvalidCodeHS),
        .RxSyncHS        (RxSyncHS),
        .RxActiveHS      (RxActiveHS),
        .ErrSotHS        (ErrSotHS),
        .ErrSotSyncHS    (ErrSotSyncHS)
    );

    initial
    begin
        RxSymClkHS = 1'b0;
        forever #(ClkPeriod / 2) RxSymClkHS = ~RxSymClkHS;
    end

    // ============================================================
    // Reference model and stimulus
    // ============================================================
    // Positive state is one-hot at the letter, negative its inverse
    function automatic logic [2:0] stateCode(input int letter, input logic positive);
        logic [2:0] oneHot;
        oneHot = 3'b100 >> letter;
        return positive ? oneHot : ~oneHot;
    endfunction

    // Entry 0 is the most significant base-5 digit
    function automatic hsWord_t refWord(input symList_t s);
        int unsigned v;
        hsWord_t     w;
        v = 0;
        for (int i = 0; i < 7; i++)
            v = v * 5 + s[i];
        w.data        = v[15:0];
        w.invalidCode = (v > 65535);
        return w;
    endfunction

    function automatic symList_t toDigits(input int unsigned value);
        symList_t    s;
        int unsigned rest;
        rest = value;
        for (int i = 6; i >= 0; i--)
        begin
            s[i] = 3'(rest % 5);
            rest = rest / 5;
        end
        return s;
    endfunction

    function automatic int pulseTotal();
        return syncCount + errSotCount + errSotSyncCount;
    endfunction

    task automatic sendSymbol(input int value);
        if (value == 4)
            curPos = !curPos;                         // Flip keeps the letter
        else
        begin
            curLetter = value[1] ? (curLetter + 1) % 3 : (curLetter + 2) % 3;
            curPos    = value[0] ? !curPos : curPos;
        end
        @(negedge RxSymClkHS);
        WireState = stateCode(curLetter, curPos);
    endtask

    task automatic startBurst();
        @(negedge RxSymClkHS);
        curLetter = 0;
        curPos    = 1'b1;
        WireState = stateCode(0, 1'b1);               // First state, no beat
        HsRxEn    = 1'b1;
    endtask

    // Trailer symbol lets the last beat reach the sync detector
    task automatic endBurst();
        sendSymbol(0);
        @(negedge RxSymClkHS);
        HsRxEn = 1'b0;
    endtask

    task automatic sendPreamble(input int len);
        repeat (len)
            sendSymbol(3);
        for (int i = 0; i < 7; i++)
            sendSymbol(SyncSymbols[i]);
    endtask

    task automatic sendWord(input symList_t s, input logic expectWord);
        if (expectWord)
            expQ.push_back(refWord(s));
        for (int i = 0; i < 7; i++)
            sendSymbol(s[i]);
    endtask

    task automatic randomWords(input int count);
        int unsigned v;
        repeat (count)
        begin
            v = $random(seed);
            sendWord(toDigits(v[15:0]), 1'b1);        // Below 65536
        end
    endtask

    // ============================================================
    // Waits and checks
    // ============================================================
    task automatic waitForWords();
        int cycles;
        cycles = 0;
        while (expQ.size() != 0 && cycles < DrainLimit)
        begin
            @(posedge RxSymClkHS);
            cycles++;
        end
        if (expQ.size() != 0)
        begin
            $display("Timed out with %0d expected words never received", expQ.size());
            errorCount++;
            expQ.delete();
        end
    endtask

    task automatic waitForPulse();
        int cycles;
        int start;
        cycles = 0;
        start  = snapSync + snapSot + snapSotSync;
        while (pulseTotal() == start && cycles < DrainLimit)
        begin
            @(posedge RxSymClkHS);
            cycles++;
        end
        if (pulseTotal() == start)
        begin
            $display("No sync or SoT error seen within %0d cycles", DrainLimit);
            errorCount++;
        end
    endtask

    task automatic checkEqual(input string what, input int got, input int expected);
        assert (got == expected)
        else
        begin
            $display("error @%0t: %s is %0d, expected %0d", $time, what, got, expected);
            errorCount++;
        end
    endtask

    // Counters move on negedges, so sample them on a posedge
    task automatic beginTest(input string name);
        @(posedge RxSymClkHS);
        testName      = name;
        errorsAtStart = errorCount;
        snapSync      = syncCount;
        snapSot       = errSotCount;
        snapSotSync   = errSotSyncCount;
        snapValid     = validCount;
        snapActive    = activeCycles;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errorCount == errorsAtStart)
            $display("Test %0d (%s): ok", testsRun, testName);
        else
        begin
            testsFailed++;
            $display("Test %0d (%s): FAILED, %0d errors", testsRun, testName,
                     errorCount - errorsAtStart);
        end
    endtask

    // Pulse and level counters
    always @(negedge RxSymClkHS)
    begin
        if (RxSyncHS)
            syncCount++;
        if (ErrSotHS)
            errSotCount++;
        if (ErrSotSyncHS)
            errSotSyncCount++;
        if (RxValidHS)
            validCount++;
        if (RxActiveHS)
            activeCycles++;
    end

    initial
    begin : compareWords
        hsWord_t expWord;
        forever
        begin
            @(negedge RxSymClkHS);
            if (RxValidHS && expQ.size() == 0)
            begin
                $display("Word %h arrived at %0t with nothing expected", RxDataHS, $time);
                errorCount++;
            end
            else if (RxValidHS)
            begin
                expWord = expQ.pop_front();           // In order, no reordering
                wordsChecked++;
                assert (RxDataHS == expWord.data)
                else
                begin
                    $display("error @%0t: RxDataHS %h, expected %h", $time, RxDataHS,
                             expWord.data);
                    errorCount++;
                end
                assert (RxInvalidCodeHS == expWord.invalidCode)
                else
                begin
                    $display("error @%0t: RxInvalidCodeHS %b, expected %b", $time,
                             RxInvalidCodeHS, expWord.invalidCode);
                    errorCount++;
                end
            end
        end
    end

    initial
    begin : watchdog
        #(CyclesPerTest * NumTests * ClkPeriod);
        $display("Watchdog expired after %0d cycles, the run hung", CyclesPerTest * NumTests);
        $display("Some tests failed");
        $finish;
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial
    begin : mainFlow
        RstN      = 1'b0;
        HsRxEn    = 1'b0;
        WireState = 3'b100;
        curLetter = 0;
        curPos    = 1'b1;
        repeat (2) @(negedge RxSymClkHS);
        RstN = 1'b1;
        repeat (3) @(negedge RxSymClkHS);

        beginTest("sync then zero word");
        startBurst();
        sendPreamble(7);
        sendWord('0, 1'b1);
        @(posedge RxSymClkHS);
        checkEqual("RxActiveHS in burst", RxActiveHS, 1);
        endBurst();
        waitForWords();
        checkEqual("RxSyncHS pulses", syncCount - snapSync, 1);
        finishTest();

        beginTest("30 random words");
        startBurst();
        sendPreamble(7);
        randomWords(30);
        endBurst();
        waitForWords();
        finishTest();

        beginTest("seven 4s invalid");
        startBurst();
        sendPreamble(7);
        sendWord({7{3'd4}}, 1'b1);                    // 78124, past 16 bits
        endBurst();
        waitForWords();
        finishTest();

        beginTest("repeated state in search");
        startBurst();
        repeat (3)
            sendSymbol(3);
        @(negedge RxSymClkHS);                        // Hold state, repeat
        sendPreamble(2);
        sendWord('0, 1'b0);
        endBurst();
        waitForPulse();
        repeat (10) @(posedge RxSymClkHS);
        checkEqual("ErrSotHS pulses", errSotCount - snapSot, 1);
        checkEqual("RxSyncHS pulses", syncCount - snapSync, 0);
        checkEqual("RxValidHS strobes", validCount - snapValid, 0);
        finishTest();

        beginTest("sync timeout");
        startBurst();
        repeat (40)
            sendSymbol($unsigned($random(seed)) % 3); // No 3 or 4, never syncs
        endBurst();
        waitForPulse();
        @(posedge RxSymClkHS);
        checkEqual("ErrSotSyncHS pulses", errSotSyncCount - snapSotSync, 1);
        checkEqual("ErrSotHS pulses", errSotCount - snapSot, 0);
        checkEqual("RxActiveHS cycles", activeCycles - snapActive, 0);
        finishTest();

        beginTest("HsRxEn drop and resync");
        startBurst();
        sendPreamble(7);
        randomWords(3);
        endBurst();
        waitForWords();
        repeat (2) @(posedge RxSymClkHS);
        checkEqual("RxActiveHS after drop", RxActiveHS, 0);
        startBurst();
        sendPreamble(5);
        randomWords(3);
        @(posedge RxSymClkHS);
        checkEqual("RxActiveHS after resync", RxActiveHS, 1);
        endBurst();
        waitForWords();
        checkEqual("RxSyncHS pulses", syncCount - snapSync, 2);
        finishTest();

        $display("Summary: %0d tests, %0d failed, %0d words checked, %0d errors",
                 testsRun, testsFailed, wordsChecked, errorCount);
        if (errorCount == 0 && testsFailed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
src/cphyRxPkg.sv
src/wireStateDecoder.sv
src/syncDetector.sv
src/symbolDeserializer.sv
src/symbolDemapper.sv
src/cphyRxTop.sv
tb/cphyRxTb.sv

//--- Bender.yml
package:
  name: cphy_rx_hs

sources:
  - src/cphyRxPkg.sv
  - src/wireStateDecoder.sv
  - src/syncDetector.sv
  - src/symbolDeserializer.sv
  - src/symbolDemapper.sv
  - src/cphyRxTop.sv
  - target: test
    files:
      - tb/cphyRxTb.sv
